//--- rv_core_pkg.sv
package rv_core_pkg;

  // datapath width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      wmask_t;    // one bit per byte lane
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  // major opcodes
  localparam opcode_t op_op     = 7'b0110011; // add, sub
  localparam opcode_t op_imm    = 7'b0010011; // addi
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_system = 7'b1110011; // only ebreak is decoded

  // load/store size codes
  localparam funct3_t f3_b  = 3'b000;
  localparam funct3_t f3_h  = 3'b001;
  localparam funct3_t f3_w  = 3'b010;
  localparam funct3_t f3_bu = 3'b100;
  localparam funct3_t f3_hu = 3'b101;

  // funct7 of sub, add uses all zeros
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // pc after reset
  localparam word_t reset_vector = 32'h8000_0000;

  // fixed instruction length
  localparam word_t inst_bytes = 32'd4;

  // write-back source
  typedef enum logic [1:0] {
    wb_alu,  // adder result
    wb_link, // pc + 4 for jal/jalr
    wb_load  // extended load data
  } wb_sel_t;

  // first adder operand
  typedef enum logic {
    a_rs1,
    a_pc
  } op_a_sel_t;

endpackage

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_core_pkg::word_t     inst,
  output rv_core_pkg::reg_addr_t rs1,
  output rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::reg_addr_t rd,
  output rv_core_pkg::word_t     imm,
  output rv_core_pkg::funct3_t   funct3,
  output logic                   sub,
  output logic                   use_rs2,
  output rv_core_pkg::op_a_sel_t op_a_sel,
  output rv_core_pkg::wb_sel_t   wb_sel,
  output logic                   reg_we,
  output logic                   mem_re,
  output logic                   mem_we,
  output logic                   jump,
  output logic                   is_ebreak
);

  rv_core_pkg::opcode_t opcode;
  logic [6:0]           funct7;
  rv_core_pkg::word_t   imm_i;
  rv_core_pkg::word_t   imm_s;
  rv_core_pkg::word_t   imm_u;
  rv_core_pkg::word_t   imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs2    = inst[24:20];

  // lui reads x0 so the adder yields imm + 0
  assign rs1 = (opcode == rv_core_pkg::op_lui) ? 5'd0 : inst[19:15];

  // sign-extended immediates per format
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    imm       = imm_i;
    sub       = 1'b0;
    use_rs2   = 1'b0;
    op_a_sel  = rv_core_pkg::a_rs1;
    wb_sel    = rv_core_pkg::wb_alu;
    reg_we    = 1'b0;
    mem_re    = 1'b0;
    mem_we    = 1'b0;
    jump      = 1'b0;
    is_ebreak = 1'b0;
    case (opcode)
      rv_core_pkg::op_op: begin
        use_rs2 = 1'b1;
        sub     = (funct7 == rv_core_pkg::funct7_sub);
        reg_we  = (funct3 == 3'b000); // only add/sub retire a result
      end
      rv_core_pkg::op_imm: begin
        reg_we = (funct3 == 3'b000); // addi
      end
      rv_core_pkg::op_lui: begin
        imm    = imm_u;
        reg_we = 1'b1;
      end
      rv_core_pkg::op_auipc: begin
        imm      = imm_u;
        op_a_sel = rv_core_pkg::a_pc;
        reg_we   = 1'b1;
      end
      rv_core_pkg::op_jal: begin
        imm      = imm_j;
        op_a_sel = rv_core_pkg::a_pc;
        wb_sel   = rv_core_pkg::wb_link;
        reg_we   = 1'b1;
        jump     = 1'b1;
      end
      rv_core_pkg::op_jalr: begin
        wb_sel = rv_core_pkg::wb_link;
        reg_we = 1'b1;
        jump   = 1'b1;
      end
      rv_core_pkg::op_load: begin
        wb_sel = rv_core_pkg::wb_load;
        reg_we = 1'b1;
        mem_re = 1'b1;
      end
      rv_core_pkg::op_store: begin
        imm    = imm_s;
        mem_we = 1'b1;
      end
      rv_core_pkg::op_system: begin
        is_ebreak = (inst[31:7] == 25'h0002000); // imm 1, all other fields zero
      end
      default: ; // unknown opcode, plain pc + 4
    endcase
  end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   we,
  input  rv_core_pkg::reg_addr_t waddr,
  input  rv_core_pkg::reg_addr_t raddr1,
  input  rv_core_pkg::reg_addr_t raddr2,
  input  rv_core_pkg::word_t     wdata,
  output rv_core_pkg::word_t     rdata1,
  output rv_core_pkg::word_t     rdata2
);

  // x1..x31, x0 has no storage
  rv_core_pkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // reads are combinational, x0 hardwired
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

//--- rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_core_pkg::word_t     pc,
  input  rv_core_pkg::word_t     rs1_data,
  input  rv_core_pkg::word_t     rs2_data,
  input  rv_core_pkg::word_t     imm,
  input  rv_core_pkg::op_a_sel_t op_a_sel,
  input  logic                   use_rs2,
  input  logic                   sub,
  input  logic                   jump,
  output rv_core_pkg::word_t     sum,
  output rv_core_pkg::word_t     pc_next,
  output rv_core_pkg::word_t     pc_plus4
);

  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t op_b;
  rv_core_pkg::word_t op_b_inv;
  rv_core_pkg::word_t carry_in;

  // pc for auipc/jal, rs1 otherwise
  assign op_a = (op_a_sel == rv_core_pkg::a_pc) ? pc : rs1_data;

  // register operand only for R-type
  assign op_b = use_rs2 ? rs2_data : imm;

  // a - b computed as a + ~b + 1
  assign op_b_inv = op_b ^ {rv_core_pkg::xlen{sub}};
  assign carry_in = {{(rv_core_pkg::xlen - 1){1'b0}}, sub};

  assign sum = op_a + op_b_inv + carry_in; // also the data address

  assign pc_plus4 = pc + rv_core_pkg::inst_bytes;

  // jump target with bit 0 dropped, needed by jalr and harmless for jal
  assign pc_next = jump ? {sum[rv_core_pkg::xlen-1:1], 1'b0} : pc_plus4;

endmodule

//--- rv_result.sv
`timescale 1ns/1ps

module rv_result (
  input  rv_core_pkg::funct3_t funct3,
  input  rv_core_pkg::word_t   sum,
  input  rv_core_pkg::word_t   mem_rdata,
  input  rv_core_pkg::word_t   rs2_data,
  input  rv_core_pkg::word_t   pc_plus4,
  input  rv_core_pkg::wb_sel_t wb_sel,
  output rv_core_pkg::word_t   wb_data,
  output rv_core_pkg::word_t   mem_wdata,
  output rv_core_pkg::wmask_t  mem_wmask
);

  logic [1:0]         offset;
  logic [7:0]         byte_sel;
  logic [15:0]        half_sel;
  logic               half_ok;
  logic               word_ok;
  rv_core_pkg::word_t load_data;

  assign offset  = sum[1:0];
  assign half_ok = (offset[0] == 1'b0);
  assign word_ok = (offset == 2'b00);

  // pick the addressed byte and half
  always_comb begin
    case (offset)
      2'd0:    byte_sel = mem_rdata[7:0];
      2'd1:    byte_sel = mem_rdata[15:8];
      2'd2:    byte_sel = mem_rdata[23:16];
      default: byte_sel = mem_rdata[31:24];
    endcase
  end

  assign half_sel = offset[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  // extension, misaligned half/word reads give zero
  always_comb begin
    case (funct3)
      rv_core_pkg::f3_b:  load_data = {{24{byte_sel[7]}}, byte_sel};
      rv_core_pkg::f3_bu: load_data = {24'h000000, byte_sel};
      rv_core_pkg::f3_h:  load_data = half_ok ? {{16{half_sel[15]}}, half_sel} : '0;
      rv_core_pkg::f3_hu: load_data = half_ok ? {16'h0000, half_sel} : '0;
      rv_core_pkg::f3_w:  load_data = word_ok ? mem_rdata : '0;
      default:            load_data = '0;
    endcase
  end

  // byte lanes written by sb/sh/sw
  always_comb begin
    case (funct3)
      rv_core_pkg::f3_b: mem_wmask = 4'b0001 << offset;
      rv_core_pkg::f3_h: mem_wmask = half_ok ? (4'b0011 << offset) : 4'b0000;
      rv_core_pkg::f3_w: mem_wmask = word_ok ? 4'b1111 : 4'b0000;
      default:           mem_wmask = 4'b0000;
    endcase
  end

  // move store data up to its lane, the mask picks the bytes
  assign mem_wdata = rs2_data << {offset, 3'b000};

  always_comb begin
    case (wb_sel)
      rv_core_pkg::wb_link: wb_data = pc_plus4;
      rv_core_pkg::wb_load: wb_data = load_data;
      default:              wb_data = sum;
    endcase
  end

endmodule

//--- rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
  input  logic                clk,
  input  logic                rst_n,
  input  rv_core_pkg::word_t  imem_data,
  input  rv_core_pkg::word_t  dmem_rdata,
  output rv_core_pkg::word_t  imem_addr,
  output rv_core_pkg::word_t  dmem_addr,
  output rv_core_pkg::word_t  dmem_wdata,
  output rv_core_pkg::wmask_t dmem_wmask,
  output logic                dmem_we,
  output logic                dmem_re,
  output logic                halt
);

  rv_core_pkg::word_t     pc;
  rv_core_pkg::reg_addr_t rs1;
  rv_core_pkg::reg_addr_t rs2;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::word_t     imm;
  rv_core_pkg::funct3_t   funct3;
  rv_core_pkg::op_a_sel_t op_a_sel;
  rv_core_pkg::wb_sel_t   wb_sel;
  logic                   sub;
  logic                   use_rs2;
  logic                   reg_we;
  logic                   mem_re;
  logic                   mem_we;
  logic                   jump;
  logic                   is_ebreak;
  rv_core_pkg::word_t     rs1_data;
  rv_core_pkg::word_t     rs2_data;
  rv_core_pkg::word_t     sum;
  rv_core_pkg::word_t     pc_next;
  rv_core_pkg::word_t     pc_plus4;
  rv_core_pkg::word_t     wb_data;
  rv_core_pkg::wmask_t    wmask;

  // pc and sticky halt, ebreak freezes pc at its own address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= rv_core_pkg::reset_vector;
      halt <= 1'b0;
    end else if (!halt) begin
      if (is_ebreak) begin
        halt <= 1'b1;
      end else begin
        pc <= pc_next;
      end
    end
  end

  assign imem_addr  = pc;
  assign dmem_addr  = sum;
  assign dmem_we    = mem_we & ~halt;
  assign dmem_re    = mem_re & ~halt;
  assign dmem_wmask = dmem_we ? wmask : 4'b0000; // lanes only shown on a store

  rv_decode decode_i (
    .inst(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .funct3(funct3),
    .sub(sub), .use_rs2(use_rs2), .op_a_sel(op_a_sel), .wb_sel(wb_sel),
    .reg_we(reg_we), .mem_re(mem_re), .mem_we(mem_we), .jump(jump),
    .is_ebreak(is_ebreak)
  );

  rv_regfile regfile_i (
    .clk(clk), .rst_n(rst_n), .we(reg_we & ~halt), .waddr(rd),
    .raddr1(rs1), .raddr2(rs2), .wdata(wb_data),
    .rdata1(rs1_data), .rdata2(rs2_data)
  );

  rv_execute execute_i (
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
    .op_a_sel(op_a_sel), .use_rs2(use_rs2), .sub(sub), .jump(jump),
    .sum(sum), .pc_next(pc_next), .pc_plus4(pc_plus4)
  );

  rv_result result_i (
    .funct3(funct3), .sum(sum), .mem_rdata(dmem_rdata), .rs2_data(rs2_data),
    .pc_plus4(pc_plus4), .wb_sel(wb_sel),
    .wb_data(wb_data), .mem_wdata(dmem_wdata), .mem_wmask(wmask)
  );

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int num_tests   = 6;
  localparam int max_cycles  = 64; // per test without reset
  localparam int clk_period  = 4;
  localparam int watchdog_ns = num_tests * max_cycles * clk_period + 1000;
  localparam int data_idx    = 128; // data area at 0x8000_0200
  localparam rv_core_pkg::word_t ebreak_inst =
    {12'd1, 5'd0, 3'b000, 5'd0, rv_core_pkg::op_system};

  logic                clk;
  logic                rst_n;
  rv_core_pkg::word_t  imem_addr;
  rv_core_pkg::word_t  imem_data;
  rv_core_pkg::word_t  dmem_addr;
  rv_core_pkg::word_t  dmem_wdata;
  rv_core_pkg::word_t  dmem_rdata;
  rv_core_pkg::wmask_t dmem_wmask;
  logic                dmem_we;
  logic                dmem_re;
  logic                halt;

  rv_core_pkg::word_t  mem [0:255] = '{default: '0};
  rv_core_pkg::word_t  image [0:255]; // copied into mem while in reset
  rv_core_pkg::wmask_t mask_log [$];  // lanes of each store in order
  int                  read_count;    // cycles with the read strobe high
  logic                fetch_patch_on;
  rv_core_pkg::word_t  fetch_patch;   // instruction forced onto the fetch port
  int                  load_idx;
  int                  test_errors;
  int                  tests_passed;
  int                  tests_failed;

  rv_core_top dut_i (
    .clk(clk), .rst_n(rst_n), .imem_data(imem_data), .dmem_rdata(dmem_rdata),
    .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_wmask(dmem_wmask), .dmem_we(dmem_we), .dmem_re(dmem_re), .halt(halt)
  );

  // 1 KiB window at the reset vector
  assign imem_data  = fetch_patch_on ? fetch_patch : mem[imem_addr[9:2]];
  assign dmem_rdata = mem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= image[i];
      end
    end else if (dmem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wmask[b]) begin
          mem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      mask_log.delete();
      read_count = 0;
    end else begin
      if (dmem_we) begin
        mask_log.push_back(dmem_wmask);
      end
      if (dmem_re) begin
        read_count++;
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: run did not finish within %0d ns", watchdog_ns);
    $display("Test FAILED");
    $finish;
  end

  function automatic rv_core_pkg::word_t addr_of(int idx);
    rv_core_pkg::word_t off;
    off = idx;
    return rv_core_pkg::reset_vector + (off << 2);
  endfunction

  // untouched words hold a value tied to their own address
  function automatic rv_core_pkg::word_t fill_word(int idx);
    return addr_of(idx) ^ 32'h5a3c_96e1;
  endfunction

  function automatic rv_core_pkg::word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic rv_core_pkg::word_t r_type(logic [6:0] funct7,
      rv_core_pkg::reg_addr_t rs2, rv_core_pkg::reg_addr_t rs1, rv_core_pkg::funct3_t f3,
      rv_core_pkg::reg_addr_t rd, rv_core_pkg::opcode_t op);
    return {funct7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t i_type(logic [11:0] imm, rv_core_pkg::reg_addr_t rs1,
      rv_core_pkg::funct3_t f3, rv_core_pkg::reg_addr_t rd, rv_core_pkg::opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t s_type(logic [11:0] imm, rv_core_pkg::reg_addr_t rs2,
      rv_core_pkg::reg_addr_t rs1, rv_core_pkg::funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::op_store};
  endfunction

  function automatic rv_core_pkg::word_t u_type(logic [19:0] imm, rv_core_pkg::reg_addr_t rd,
      rv_core_pkg::opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t j_type(logic [20:0] imm, rv_core_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::op_jal};
  endfunction

  // value a load should return by the size and extension rules
  function automatic rv_core_pkg::word_t expect_load(rv_core_pkg::funct3_t f3,
      rv_core_pkg::word_t w, int off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*off +: 8];
    h = w[8*(off & 2) +: 16];
    case (f3)
      rv_core_pkg::f3_b:  return {{24{b[7]}}, b};
      rv_core_pkg::f3_bu: return {24'h0, b};
      rv_core_pkg::f3_h:  return (off % 2 == 0) ? {{16{h[15]}}, h} : 32'h0;
      rv_core_pkg::f3_hu: return (off % 2 == 0) ? {16'h0, h} : 32'h0;
      rv_core_pkg::f3_w:  return (off == 0) ? w : 32'h0;
      default:            return 32'h0;
    endcase
  endfunction

  task automatic emit(rv_core_pkg::word_t inst);
    image[load_idx] = inst;
    load_idx++;
  endtask

  // lui + addi with the hi part rounded up for the signed low part
  task automatic load_const(rv_core_pkg::reg_addr_t rd, rv_core_pkg::word_t value);
    rv_core_pkg::word_t hi;
    hi = value + 32'h0000_0800;
    emit(u_type(hi[31:12], rd, rv_core_pkg::op_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, rv_core_pkg::op_imm));
  endtask

  task automatic fill_image();
    for (int i = 0; i < 256; i++) begin
      image[i] = fill_word(i);
    end
  endtask

  task automatic begin_test();
    @(negedge clk);
    rst_n = 1'b0;
    test_errors = 0;
    load_idx = 0;
    fill_image();
  endtask

  task automatic release_reset();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    while (!halt && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      $display("error at %0t: core did not reach ebreak in %0d cycles", $time, max_cycles);
      test_errors++;
    end
  endtask

  task automatic end_test(string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", name, test_errors);
    end
  endtask

  task automatic check_word(string name, rv_core_pkg::word_t exp, rv_core_pkg::word_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_mask(string name, rv_core_pkg::wmask_t exp, rv_core_pkg::wmask_t act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic reset_state();
    begin_test();
    emit(ebreak_inst);
    release_reset();
    check_word("imem_addr", rv_core_pkg::reset_vector, imem_addr);
    check_bit("dmem_we", 1'b0, dmem_we);
    check_bit("dmem_re", 1'b0, dmem_re);
    check_bit("halt", 1'b0, halt);
    wait_halt();
    check_word("imem_addr", rv_core_pkg::reset_vector, imem_addr);
    end_test("reset_state");
  endtask

  task automatic arith_store();
    rv_core_pkg::word_t ra;
    rv_core_pkg::word_t b;
    begin_test();
    ra = $urandom;
    b  = $urandom;
    load_const(5'd10, addr_of(data_idx));
    emit(i_type(ra[11:0], 5'd0, 3'b000, 5'd1, rv_core_pkg::op_imm));
    load_const(5'd2, b);
    emit(r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd3, rv_core_pkg::op_op));
    emit(r_type(rv_core_pkg::funct7_sub, 5'd2, 5'd1, 3'b000, 5'd4, rv_core_pkg::op_op));
    emit(i_type(12'd5, 5'd1, 3'b000, 5'd0, rv_core_pkg::op_imm)); // x0 stays zero
    emit(r_type(7'd0, 5'd2, 5'd1, 3'b000, 5'd0, rv_core_pkg::op_op));
    emit(s_type(12'd0, 5'd3, 5'd10, rv_core_pkg::f3_w));
    emit(s_type(12'd4, 5'd4, 5'd10, rv_core_pkg::f3_w));
    emit(s_type(12'd8, 5'd0, 5'd10, rv_core_pkg::f3_w));
    emit(ebreak_inst);
    release_reset();
    wait_halt();
    check_word("mem add", sext12(ra[11:0]) + b, mem[data_idx]);
    check_word("mem sub", sext12(ra[11:0]) - b, mem[data_idx + 1]);
    check_word("mem x0", 32'h0, mem[data_idx + 2]);
    end_test("arith_store");
  endtask

  task automatic upper_imm();
    rv_core_pkg::word_t ru;
    rv_core_pkg::word_t auipc_addr;
    begin_test();
    ru = $urandom;
    load_const(5'd10, addr_of(data_idx));
    emit(u_type(ru[19:0], 5'd1, rv_core_pkg::op_lui));
    auipc_addr = addr_of(load_idx);
    emit(u_type(ru[19:0], 5'd2, rv_core_pkg::op_auipc));
    emit(s_type(12'd0, 5'd1, 5'd10, rv_core_pkg::f3_w));
    emit(s_type(12'd4, 5'd2, 5'd10, rv_core_pkg::f3_w));
    emit(ebreak_inst);
    release_reset();
    wait_halt();
    check_word("mem lui", {ru[19:0], 12'h000}, mem[data_idx]);
    check_word("mem auipc", {ru[19:0], 12'h000} + auipc_addr, mem[data_idx + 1]);
    end_test("upper_imm");
  endtask

  task automatic store_lanes();
    rv_core_pkg::word_t  val;
    rv_core_pkg::word_t  exp;
    rv_core_pkg::wmask_t exp_mask [$];
    rv_core_pkg::word_t  exp_mem [$];
    int                  off;
    begin_test();
    val = $urandom;
    load_const(5'd10, addr_of(data_idx));
    load_const(5'd1, val);
    for (off = 0; off < 4; off++) begin
      emit(s_type(12'(5 * off), 5'd1, 5'd10, rv_core_pkg::f3_b)); // byte off of word off
      exp = fill_word(data_idx + off);
      exp[8*off +: 8] = val[7:0];
      exp_mem.push_back(exp);
      exp_mask.push_back(4'b0001 << off);
    end
    for (int k = 0; k < 3; k++) begin
      off = (k == 2) ? 1 : 2 * k; // last one misaligned
      emit(s_type(12'(16 + 4 * k + off), 5'd1, 5'd10, rv_core_pkg::f3_h));
      exp = fill_word(data_idx + 4 + k);
      if (off % 2 == 0) begin
        exp[8*off +: 16] = val[15:0];
        exp_mask.push_back(4'b0011 << off);
      end else begin
        exp_mask.push_back(4'b0000);
      end
      exp_mem.push_back(exp);
    end
    emit(ebreak_inst);
    release_reset();
    wait_halt();
    if (mask_log.size() != exp_mask.size()) begin
      $display("error: saw %0d stores, expected %0d", mask_log.size(), exp_mask.size());
      test_errors++;
    end else begin
      for (int k = 0; k < exp_mask.size(); k++) begin
        check_mask($sformatf("dmem_wmask of store %0d", k), exp_mask[k], mask_log[k]);
      end
    end
    for (int k = 0; k < exp_mem.size(); k++) begin
      check_word($sformatf("mem[%h]", addr_of(data_idx + k)), exp_mem[k], mem[data_idx + k]);
    end
    end_test("store_lanes");
  endtask

  task automatic load_extend();
    rv_core_pkg::funct3_t kinds [$];
    int                   offs [$];
    rv_core_pkg::word_t   w;
    begin_test();
    w = ($urandom & 32'h7f7f_7f7f) | 32'h8000_0080; // bytes 0 and 3 negative
    image[data_idx] = w;
    for (int off = 0; off < 4; off++) begin
      kinds.push_back(rv_core_pkg::f3_b);
      offs.push_back(off);
      kinds.push_back(rv_core_pkg::f3_bu);
      offs.push_back(off);
    end
    for (int off = 0; off < 4; off += 2) begin
      kinds.push_back(rv_core_pkg::f3_h);
      offs.push_back(off);
      kinds.push_back(rv_core_pkg::f3_hu);
      offs.push_back(off);
    end
    kinds.push_back(rv_core_pkg::f3_w);
    offs.push_back(0);
    kinds.push_back(rv_core_pkg::f3_h); // misaligned
    offs.push_back(1);
    kinds.push_back(rv_core_pkg::f3_w); // misaligned
    offs.push_back(2);
    load_const(5'd10, addr_of(data_idx));
    for (int k = 0; k < kinds.size(); k++) begin
      emit(i_type(12'(offs[k]), 5'd10, kinds[k], 5'd1, rv_core_pkg::op_load));
      emit(s_type(12'(4 + 4 * k), 5'd1, 5'd10, rv_core_pkg::f3_w));
    end
    emit(ebreak_inst);
    release_reset();
    wait_halt();
    if (read_count != kinds.size()) begin
      $display("error: saw %0d loads, expected %0d", read_count, kinds.size());
      test_errors++;
    end
    for (int k = 0; k < kinds.size(); k++) begin
      check_word($sformatf("load funct3 %0d offset %0d", kinds[k], offs[k]),
                 expect_load(kinds[k], w, offs[k]), mem[data_idx + 1 + k]);
    end
    end_test("load_extend");
  endtask

  task automatic jump_and_halt();
    rv_core_pkg::word_t jal_addr;
    rv_core_pkg::word_t jalr_addr;
    rv_core_pkg::word_t halt_addr;
    begin_test();
    load_const(5'd10, addr_of(data_idx));
    jal_addr = addr_of(load_idx);
    emit(j_type(21'd8, 5'd1));
    emit(i_type(12'd99, 5'd0, 3'b000, 5'd5, rv_core_pkg::op_imm)); // skipped
    emit(s_type(12'd0, 5'd1, 5'd10, rv_core_pkg::f3_w));
    load_const(5'd6, addr_of(load_idx + 4)); // target past jalr and its shadow
    jalr_addr = addr_of(load_idx);
    emit(i_type(12'd1, 5'd6, 3'b000, 5'd2, rv_core_pkg::op_jalr)); // odd target
    emit(i_type(12'd77, 5'd0, 3'b000, 5'd5, rv_core_pkg::op_imm)); // skipped
    emit(s_type(12'd4, 5'd2, 5'd10, rv_core_pkg::f3_w));
    emit(s_type(12'd8, 5'd5, 5'd10, rv_core_pkg::f3_w));
    halt_addr = addr_of(load_idx);
    emit(ebreak_inst);
    release_reset();
    wait_halt();
    check_word("mem jal link", jal_addr + 32'd4, mem[data_idx]);
    check_word("mem jalr link", jalr_addr + 32'd4, mem[data_idx + 1]);
    check_word("mem skipped x5", 32'h0, mem[data_idx + 2]);
    for (int c = 0; c < 10; c++) begin
      // a store and then a load show up at the frozen pc
      if (c < 5) begin
        fetch_patch = s_type(12'd12, 5'd1, 5'd10, rv_core_pkg::f3_w);
      end else begin
        fetch_patch = i_type(12'd0, 5'd10, rv_core_pkg::f3_w, 5'd7, rv_core_pkg::op_load);
      end
      fetch_patch_on = 1'b1;
      @(negedge clk);
      check_bit("halt", 1'b1, halt);
      check_word("imem_addr", halt_addr, imem_addr);
      check_bit("dmem_we", 1'b0, dmem_we);
      check_bit("dmem_re", 1'b0, dmem_re);
    end
    fetch_patch_on = 1'b0;
    check_word("mem after halt", fill_word(data_idx + 3), mem[data_idx + 3]);
    end_test("jump_and_halt");
  endtask

  initial begin
    rst_n = 1'b0;
    fetch_patch_on = 1'b0;
    fetch_patch = '0;
    load_idx = 0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    fill_image();
    void'($urandom(32'hddec_57f8));
    reset_state();
    arith_store();
    upper_imm();
    store_lanes();
    load_extend();
    jump_and_halt();
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- rv_core.f
rv_core_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o sim_rv_core \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/sim_rv_core > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
